// ==== fpm_consts.svh ====
`ifndef FPM_CONSTS_SVH
`define FPM_CONSTS_SVH

// Word layout: exc[17:16], sign[15], exp[14:10], frac[9:0]
`define FPM_EXP_W    5
`define FPM_FRAC_W   10
`define FPM_WORD_W   18
`define FPM_BIAS     15
`define FPM_EXC_MSB  17
`define FPM_SIGN_BIT 15
`define FPM_EXP_LSB  10

// Lane count, also the size of one operand group
`define FPM_LANES    4

`endif

// ==== fpm_pkg.sv ====
package fpm_pkg;

	//////////////////////////////////////////////////////////////////////
	// Exception class, held in the top two bits of every word
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [1:0]
	{
		EXC_ZERO   = 2'd0,
		EXC_NORMAL = 2'd1,
		EXC_INF    = 2'd2,
		EXC_NAN    = 2'd3
	} fp_exc_t;

	// Result collector FSM
	typedef enum logic
	{
		COLL_IDLE  = 1'b0,
		COLL_DRAIN = 1'b1
	} coll_state_t;

endpackage

// ==== special_cases_mul.sv ====
`timescale 1ns/1ps
`include "fpm_consts.svh"

module special_cases_mul
(
	input  fpm_pkg::fp_exc_t exc_a_i,
	input  fpm_pkg::fp_exc_t exc_b_i,
	output fpm_pkg::fp_exc_t exc_o
);
	import fpm_pkg::*;

	logic a_zero_b_inf;
	logic both_inf;

	// Invalid products, 0 * inf in either order
	assign a_zero_b_inf = (exc_a_i == EXC_ZERO && exc_b_i == EXC_INF) ||
		(exc_a_i == EXC_INF && exc_b_i == EXC_ZERO);
	assign both_inf = (exc_a_i == EXC_INF) && (exc_b_i == EXC_INF);

	// Rules in priority order
	always_comb
	begin
		if (exc_a_i == EXC_NAN || exc_b_i == EXC_NAN)
			// NaN propagates
			exc_o = EXC_NAN;
		else if (a_zero_b_inf || both_inf)
			// inf * inf is treated as invalid here too
			exc_o = EXC_NAN;
		else if (exc_a_i == EXC_ZERO || exc_b_i == EXC_ZERO)
			exc_o = EXC_ZERO;
		else if (exc_a_i == EXC_INF || exc_b_i == EXC_INF)
			// Only inf * normal is left
			exc_o = EXC_INF;
		else
			exc_o = EXC_NORMAL;
	end

endmodule

// ==== fpm_operand_dispatch.sv ====
`timescale 1ns/1ps
`include "fpm_consts.svh"

module fpm_operand_dispatch
(
	input  logic                              clk,
	input  logic                              rst_i,
	input  logic                              in_valid_i,
	input  logic [`FPM_WORD_W-1:0]            a_i,
	input  logic [`FPM_WORD_W-1:0]            b_i,
	output logic                              grp_valid_o,
	output logic [`FPM_LANES*`FPM_WORD_W-1:0] grp_a_o,
	output logic [`FPM_LANES*`FPM_WORD_W-1:0] grp_b_o
);
	localparam int W = `FPM_WORD_W;
	localparam int SLOT_W = $clog2(`FPM_LANES);
	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`FPM_LANES - 1);

	// Next free slot of the group being gathered
	logic [SLOT_W-1:0] slot_q;
	// Staging for the first LANES-1 pairs, last pair goes straight out
	logic [(`FPM_LANES-1)*W-1:0] stage_a_q;
	logic [(`FPM_LANES-1)*W-1:0] stage_b_q;
	logic last_slot;

	// Pair accepted into the final slot
	assign last_slot = in_valid_i && (slot_q == LAST_SLOT);

	//////////////////////////////////////////////////////////////////////
	// Slot counter and group strobe
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			// Partial group is dropped here
			slot_q      <= '0;
			grp_valid_o <= 1'b0;
		end
		else
		begin
			grp_valid_o <= last_slot;
			if (in_valid_i)
				slot_q <= last_slot ? '0 : slot_q + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Staging and group registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		// Slot k lands in word k
		if (in_valid_i && !last_slot)
		begin
			stage_a_q[slot_q*W +: W] <= a_i;
			stage_b_q[slot_q*W +: W] <= b_i;
		end
		// Whole group out, staging free again on the next edge
		if (last_slot)
		begin
			grp_a_o <= {a_i, stage_a_q};
			grp_b_o <= {b_i, stage_b_q};
		end
	end

endmodule

// ==== fpm_lane.sv ====
`timescale 1ns/1ps
`include "fpm_consts.svh"

module fpm_lane
(
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   valid_i,
	input  logic [`FPM_WORD_W-1:0] a_i,
	input  logic [`FPM_WORD_W-1:0] b_i,
	output logic                   valid_o,
	output logic [`FPM_WORD_W-1:0] result_o
);
	import fpm_pkg::*;

	localparam int MANT_W = `FPM_FRAC_W + 1;
	localparam int PROD_W = 2 * MANT_W;
	// Signed exponent, room for -15 .. 49
	localparam int SEXP_W = `FPM_EXP_W + 2;
	localparam logic signed [SEXP_W-1:0] BIAS = SEXP_W'(`FPM_BIAS);
	localparam logic signed [SEXP_W-1:0] EXP_MAX = SEXP_W'((1 << `FPM_EXP_W) - 1);

	// Operand fields
	fp_exc_t exc_a;
	fp_exc_t exc_b;
	fp_exc_t exc_ab;
	logic [`FPM_EXP_W-1:0] exp_a;
	logic [`FPM_EXP_W-1:0] exp_b;
	logic [MANT_W-1:0] mant_a;
	logic [MANT_W-1:0] mant_b;

	// Stage 1 registers
	logic s1_valid_q;
	fp_exc_t s1_exc_q;
	logic s1_sign_q;
	logic signed [SEXP_W-1:0] s1_exp_q;
	logic [PROD_W-1:0] s1_prod_q;

	// Stage 2 datapath
	logic [PROD_W-1:0] norm;
	logic signed [SEXP_W-1:0] exp_norm;
	logic signed [SEXP_W-1:0] exp_round;
	logic guard;
	logic sticky;
	logic lsb;
	logic [MANT_W-1:0] frac_round;
	fp_exc_t exc_res;
	logic [`FPM_WORD_W-1:0] packed_word;

	assign exc_a  = fp_exc_t'(a_i[`FPM_EXC_MSB -: $bits(fp_exc_t)]);
	assign exc_b  = fp_exc_t'(b_i[`FPM_EXC_MSB -: $bits(fp_exc_t)]);
	assign exp_a  = a_i[`FPM_EXP_LSB +: `FPM_EXP_W];
	assign exp_b  = b_i[`FPM_EXP_LSB +: `FPM_EXP_W];
	// Hidden leading one
	assign mant_a = {1'b1, a_i[`FPM_FRAC_W-1:0]};
	assign mant_b = {1'b1, b_i[`FPM_FRAC_W-1:0]};

	special_cases_mul i_special_cases_mul
	(
		.exc_a_i (exc_a),
		.exc_b_i (exc_b),
		.exc_o   (exc_ab)
	);

	//////////////////////////////////////////////////////////////////////
	// Stage 1: class, sign, exponent sum, mantissa product
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst_i)
			s1_valid_q <= 1'b0;
		else
			s1_valid_q <= valid_i;
	end

	always_ff @(posedge clk)
	begin
		s1_exc_q  <= exc_ab;
		s1_sign_q <= a_i[`FPM_SIGN_BIT] ^ b_i[`FPM_SIGN_BIT];
		s1_exp_q  <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - BIAS;
		s1_prod_q <= mant_a * mant_b;
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 2: normalize, round, range check, pack
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		// Product in [1,4), bring it to 1.x at the top bit
		norm     = s1_prod_q[PROD_W-1] ? s1_prod_q : (s1_prod_q << 1);
		exp_norm = s1_exp_q + $signed({{(SEXP_W-1){1'b0}}, s1_prod_q[PROD_W-1]});

		// Guard right below the kept fraction, sticky is all the rest
		lsb    = norm[PROD_W-MANT_W];
		guard  = norm[PROD_W-MANT_W-1];
		sticky = |norm[PROD_W-MANT_W-2:0];

		// Nearest-even, carry out means fraction wrapped to zero
		frac_round = {1'b0, norm[PROD_W-2 -: `FPM_FRAC_W]} + MANT_W'(guard & (sticky | lsb));
		exp_round  = exp_norm + $signed({{(SEXP_W-1){1'b0}}, frac_round[MANT_W-1]});

		// Range limits apply to normal products only
		exc_res = s1_exc_q;
		if (s1_exc_q == EXC_NORMAL)
		begin
			if (exp_round > EXP_MAX)
				exc_res = EXC_INF;
			else if (exp_round < 0)
				exc_res = EXC_ZERO;
		end

		// Non-normal words carry sign only
		if (exc_res == EXC_NORMAL)
			packed_word = {exc_res, s1_sign_q, exp_round[`FPM_EXP_W-1:0],
				frac_round[`FPM_FRAC_W-1:0]};
		else
			packed_word = {exc_res, s1_sign_q, {(`FPM_EXP_W + `FPM_FRAC_W){1'b0}}};
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			valid_o <= 1'b0;
		else
			valid_o <= s1_valid_q;
	end

	always_ff @(posedge clk)
	begin
		result_o <= packed_word;
	end

endmodule

// ==== fpm_result_collect.sv ====
`timescale 1ns/1ps
`include "fpm_consts.svh"

module fpm_result_collect
(
	input  logic                              clk,
	input  logic                              rst_i,
	input  logic                              load_i,
	input  logic [`FPM_LANES*`FPM_WORD_W-1:0] results_i,
	output logic                              out_valid_o,
	output logic [`FPM_WORD_W-1:0]            result_o
);
	import fpm_pkg::*;

	localparam int W = `FPM_WORD_W;
	localparam int IDX_W = $clog2(`FPM_LANES);
	// Index of the word issued on the edge that leaves DRAIN
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`FPM_LANES - 2);

	coll_state_t state_q;
	// Words 1..LANES-1 still to go, next one in the low word
	logic [(`FPM_LANES-1)*W-1:0] shift_q;
	logic [IDX_W-1:0] idx_q;

	//////////////////////////////////////////////////////////////////////
	// Collector FSM, output word is registered
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q     <= COLL_IDLE;
			idx_q       <= '0;
			out_valid_o <= 1'b0;
		end
		else
		begin
			case (state_q)
				COLL_IDLE:
				begin
					// Word 0 goes out on the load edge itself
					out_valid_o <= load_i;
					idx_q       <= '0;
					if (load_i)
						state_q <= COLL_DRAIN;
				end
				default:
				begin
					out_valid_o <= 1'b1;
					idx_q       <= idx_q + 1'b1;
					// Back to idle as the last word is issued
					if (idx_q == LAST_IDX)
						state_q <= COLL_IDLE;
				end
			endcase
		end
	end

	// Data path, lane order
	always_ff @(posedge clk)
	begin
		if (state_q == COLL_IDLE)
		begin
			if (load_i)
			begin
				result_o <= results_i[W-1:0];
				shift_q  <= results_i[`FPM_LANES*W-1:W];
			end
		end
		else
		begin
			result_o <= shift_q[W-1:0];
			shift_q  <= shift_q >> W;
		end
	end

endmodule

// ==== fpm_vector_mul.sv ====
`timescale 1ns/1ps
`include "fpm_consts.svh"

module fpm_vector_mul
(
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   in_valid_i,
	input  logic [`FPM_WORD_W-1:0] a_i,
	input  logic [`FPM_WORD_W-1:0] b_i,
	output logic                   out_valid_o,
	output logic [`FPM_WORD_W-1:0] result_o
);
	localparam int W = `FPM_WORD_W;

	//////////////////////////////////////////////////////////////////////
	// Internal buses
	//////////////////////////////////////////////////////////////////////
	// Group strobe and operands, lane k on word k
	logic                      grp_valid;
	logic [`FPM_LANES*W-1:0]   grp_a;
	logic [`FPM_LANES*W-1:0]   grp_b;
	// Per-lane strobes, all in lockstep
	logic [`FPM_LANES-1:0]     lane_valid;
	logic [`FPM_LANES*W-1:0]   lane_result;

	// Serial pairs to one group
	fpm_operand_dispatch i_operand_dispatch
	(
		.clk         (clk),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.a_i         (a_i),
		.b_i         (b_i),
		.grp_valid_o (grp_valid),
		.grp_a_o     (grp_a),
		.grp_b_o     (grp_b)
	);

	// One multiplier per slot
	genvar k;
	generate
		for (k = 0; k < `FPM_LANES; k++)
		begin : g_lane
			fpm_lane i_lane
			(
				.clk      (clk),
				.rst_i    (rst_i),
				.valid_i  (grp_valid),
				.a_i      (grp_a[k*W +: W]),
				.b_i      (grp_b[k*W +: W]),
				.valid_o  (lane_valid[k]),
				.result_o (lane_result[k*W +: W])
			);
		end
	endgenerate

	// Lane 0 strobe stands for the whole group
	fpm_result_collect i_result_collect
	(
		.clk         (clk),
		.rst_i       (rst_i),
		.load_i      (lane_valid[0]),
		.results_i   (lane_result),
		.out_valid_o (out_valid_o),
		.result_o    (result_o)
	);

endmodule

// ==== fpm_properties.sv ====
`timescale 1ns/1ps
`include "fpm_consts.svh"

module fpm_properties
(
	input logic                          clk,
	input logic                          rst_i,
	input logic                          out_valid_i,
	input logic [`FPM_WORD_W-1:0]        result_i,
	input logic [`FPM_LANES-1:0]         lane_valid_i,
	input fpm_pkg::coll_state_t          coll_state_i,
	input logic                          coll_load_i
);
	import fpm_pkg::*;

	// Output strobe cleared by the reset edge
	a_out_valid_rst: assert property (@(posedge clk) rst_i |=> !out_valid_i)
		else $error("out_valid_o high during reset");

	// Lanes in lockstep
	a_lane_sync: assert property (@(posedge clk) disable iff (rst_i)
		(lane_valid_i == '0) || (lane_valid_i == '1))
		else $error("lane valid strobes disagree");

	// Load only into an idle collector
	a_no_load_drain: assert property (@(posedge clk) disable iff (rst_i)
		coll_load_i |-> coll_state_i == COLL_IDLE)
		else $error("collector loaded while draining");

	a_result_known: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_i |-> !$isunknown(result_i))
		else $error("result_o has unknown bits while valid");

endmodule

// ==== tb_fpm_vector_mul.sv ====
`timescale 1ns/1ps
`include "fpm_consts.svh"

module tb_fpm_vector_mul;
	import fpm_pkg::*;

	localparam int W = `FPM_WORD_W;
	localparam logic [31:0] SEED = 32'ha4b2_f6f1;
	localparam int RESET_CYCLES = 16;
	// Edges from the edge taking a group's fourth pair to the edge showing result 0
	localparam int LAT_EDGES = 3;
	localparam int MAX_GAP = 3;
	localparam int TOTAL_PAIRS = 16 + 8 + 8 + 8 + 20 + 2 + 4 + 200;
	// Every pair may sit behind a full gap plus drain and reset slack per test
	localparam int LIMIT_CYCLES = RESET_CYCLES + TOTAL_PAIRS * (MAX_GAP + 1) + 6 * 40;

	logic clk;
	logic rst_i;
	logic in_valid_i;
	logic [W-1:0] a_i;
	logic [W-1:0] b_i;
	logic out_valid_o;
	logic [W-1:0] result_o;

	logic [31:0] lfsr_q = SEED;
	logic [W-1:0] exp_q[$];
	int acc_q[$];
	int edge_cnt = 0;
	int pair_cnt = 0;
	int out_idx = 0;
	int gap_cnt = 0;
	int err_cnt = 0;
	int check_cnt = 0;
	int test_cnt = 0;
	logic prev_out = 1'b0;

	fpm_vector_mul i_fpm_vector_mul
	(
		.clk         (clk),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.a_i         (a_i),
		.b_i         (b_i),
		.out_valid_o (out_valid_o),
		.result_o    (result_o)
	);

	// Assertions on the top level strobes
	bind fpm_vector_mul fpm_properties i_fpm_properties
	(
		.clk          (clk),
		.rst_i        (rst_i),
		.out_valid_i  (out_valid_o),
		.result_i     (result_o),
		.lane_valid_i (lane_valid),
		.coll_state_i (i_result_collect.state_q),
		.coll_load_i  (lane_valid[0])
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [W-1:0] make_word(input fp_exc_t exc, input logic sign,
		input logic [`FPM_EXP_W-1:0] exp, input logic [`FPM_FRAC_W-1:0] frac);
		return {exc, sign, exp, frac};
	endfunction

	function automatic logic [W-1:0] rand_normal();
		return make_word(EXC_NORMAL, rand_bits(1), rand_bits(5), rand_bits(10));
	endfunction

	// Reference product from exact integer mantissa math and nearest-even rounding
	function automatic logic [W-1:0] model_product(input logic [W-1:0] a,
		input logic [W-1:0] b);
		fp_exc_t ca;
		fp_exc_t cb;
		fp_exc_t cr;
		logic sign;
		int e;
		int shift;
		longint prod;
		longint kept;
		longint rem;
		longint half;
		ca = fp_exc_t'(a[`FPM_EXC_MSB -: 2]);
		cb = fp_exc_t'(b[`FPM_EXC_MSB -: 2]);
		sign = a[`FPM_SIGN_BIT] ^ b[`FPM_SIGN_BIT];
		if (ca == EXC_NAN || cb == EXC_NAN)
			cr = EXC_NAN;
		else if ((ca == EXC_INF && cb != EXC_NORMAL) || (cb == EXC_INF && ca != EXC_NORMAL))
			cr = EXC_NAN;
		else if (ca == EXC_ZERO || cb == EXC_ZERO)
			cr = EXC_ZERO;
		else if (ca == EXC_INF || cb == EXC_INF)
			cr = EXC_INF;
		else
			cr = EXC_NORMAL;
		if (cr != EXC_NORMAL)
			return {cr, sign, 15'd0};
		e = int'(a[`FPM_EXP_LSB +: 5]) + int'(b[`FPM_EXP_LSB +: 5]) - `FPM_BIAS;
		prod = longint'(1024 + a[9:0]) * longint'(1024 + b[9:0]);
		// Product of 2.0 or more keeps one more low bit out
		if (prod >= (64'd1 << 21))
		begin
			shift = 11;
			e++;
		end
		else
			shift = 10;
		kept = prod >> shift;
		rem = prod - (kept << shift);
		half = 64'd1 << (shift - 1);
		if (rem > half || (rem == half && (kept % 2) == 1))
			kept++;
		if (kept == 2048)
		begin
			kept = 1024;
			e++;
		end
		if (e > 31)
			return {EXC_INF, sign, 15'd0};
		if (e < 0)
			return {EXC_ZERO, sign, 15'd0};
		return {EXC_NORMAL, sign, 5'(e), 10'(kept)};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_cnt++;
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic drive_pair(input logic [W-1:0] a, input logic [W-1:0] b);
		@(negedge clk);
		in_valid_i = 1'b1;
		a_i = a;
		b_i = b;
	endtask

	task automatic push_pair(input logic [W-1:0] a, input logic [W-1:0] b);
		drive_pair(a, b);
		exp_q.push_back(model_product(a, b));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge clk);
			in_valid_i = 1'b0;
		end
	endtask

	// Drop the strobe and wait for every owed result
	task automatic drain_outputs();
		idle_cycles(1);
		while (exp_q.size() != 0)
			@(negedge clk);
		idle_cycles(2);
	endtask

	// One summary line per finished test
	task automatic report_test(input string name, input int start_err);
		test_cnt++;
		$display("Test %s done, %0d errors", name, err_cnt - start_err);
	endtask

	task automatic end_test(input string name, input int start_err);
		drain_outputs();
		report_test(name, start_err);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Accept tracking and output monitor
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk)
	begin
		edge_cnt++;
		if (rst_i)
			pair_cnt = 0;
		else if (in_valid_i)
		begin
			pair_cnt++;
			// Group complete on this edge
			if (pair_cnt == `FPM_LANES)
			begin
				acc_q.push_back(edge_cnt);
				pair_cnt = 0;
			end
		end
	end

	always @(negedge clk)
	begin
		if (rst_i)
		begin
			out_idx = 0;
			acc_q.delete();
		end
		else if (out_valid_o)
		begin
			if (exp_q.size() == 0)
			begin
				$display("A result came out while none was expected");
				err_cnt++;
			end
			else
				check_value("result_o", result_o, exp_q.pop_front());
			if (out_idx == 0)
			begin
				if (acc_q.size() == 0)
				begin
					$display("A result group started without a complete input group");
					err_cnt++;
				end
				else
					check_value("first_result_edges", edge_cnt - acc_q.pop_front(), LAT_EDGES);
			end
			out_idx = (out_idx + 1) % `FPM_LANES;
		end
		// Hole in the output while results are still owed
		if (!rst_i && prev_out && !out_valid_o && exp_q.size() != 0)
			gap_cnt++;
		prev_out = out_valid_o;
	end

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic test_exc_table();
		int start;
		start = err_cnt;
		for (int ca = 0; ca < 4; ca++)
			for (int cb = 0; cb < 4; cb++)
				push_pair(make_word(fp_exc_t'(ca), rand_bits(1), rand_bits(5), rand_bits(10)),
					make_word(fp_exc_t'(cb), rand_bits(1), rand_bits(5), rand_bits(10)));
		end_test("exc_table", start);
	endtask

	task automatic test_exact();
		int start;
		start = err_cnt;
		// 1.5 * 2.0 with the model also held to a literal result
		push_pair(make_word(EXC_NORMAL, 0, 15, 10'h200), make_word(EXC_NORMAL, 0, 16, 0));
		check_value("model_1p5x2", model_product(make_word(EXC_NORMAL, 0, 15, 10'h200),
			make_word(EXC_NORMAL, 0, 16, 0)), make_word(EXC_NORMAL, 0, 16, 10'h200));
		push_pair(make_word(EXC_NORMAL, 0, 15, 0), make_word(EXC_NORMAL, 0, 15, 0));
		push_pair(make_word(EXC_NORMAL, 1, 15, 10'h200), make_word(EXC_NORMAL, 0, 15, 10'h200));
		push_pair(make_word(EXC_NORMAL, 1, 17, 10'h300), make_word(EXC_NORMAL, 1, 12, 10'h100));
		// Top mantissa bit set
		push_pair(make_word(EXC_NORMAL, 0, 14, 10'h3c0), make_word(EXC_NORMAL, 0, 15, 10'h380));
		push_pair(make_word(EXC_NORMAL, 0, 20, 10'h3ff), make_word(EXC_NORMAL, 1, 9, 10'h3ff));
		push_pair(make_word(EXC_NORMAL, 0, 15, 10'h0c0), make_word(EXC_NORMAL, 0, 15, 10'h0c0));
		push_pair(make_word(EXC_NORMAL, 1, 3, 10'h155), make_word(EXC_NORMAL, 0, 25, 10'h2aa));
		end_test("exact", start);
	endtask

	task automatic test_rounding();
		int start;
		start = err_cnt;
		// Mantissas 1025 * 1536 tie on an odd fraction and round up
		push_pair(make_word(EXC_NORMAL, 0, 15, 10'd1), make_word(EXC_NORMAL, 0, 15, 10'd512));
		// 1027 * 1536 ties on an even fraction and stays
		push_pair(make_word(EXC_NORMAL, 0, 15, 10'd3), make_word(EXC_NORMAL, 0, 15, 10'd512));
		// 1448 * 1448 rounds up into the exponent
		push_pair(make_word(EXC_NORMAL, 0, 15, 10'd424), make_word(EXC_NORMAL, 1, 15, 10'd424));
		push_pair(make_word(EXC_NORMAL, 1, 10, 10'd424), make_word(EXC_NORMAL, 0, 18, 10'd424));
		for (int i = 0; i < 4; i++)
			push_pair(rand_normal(), rand_normal());
		end_test("rounding", start);
	endtask

	task automatic test_range();
		int start;
		start = err_cnt;
		push_pair(make_word(EXC_NORMAL, 0, 31, 0), make_word(EXC_NORMAL, 0, 16, 0));
		push_pair(make_word(EXC_NORMAL, 1, 30, 0), make_word(EXC_NORMAL, 0, 16, 0));
		push_pair(make_word(EXC_NORMAL, 0, 0, 0), make_word(EXC_NORMAL, 0, 15, 0));
		push_pair(make_word(EXC_NORMAL, 0, 0, 0), make_word(EXC_NORMAL, 1, 14, 0));
		// Normalization pushes 31 over and lifts -1 back to 0
		push_pair(make_word(EXC_NORMAL, 0, 30, 10'h200), make_word(EXC_NORMAL, 0, 16, 10'h200));
		push_pair(make_word(EXC_NORMAL, 0, 0, 10'h200), make_word(EXC_NORMAL, 0, 14, 10'h200));
		push_pair(make_word(EXC_NORMAL, 0, 31, 10'h3ff), make_word(EXC_NORMAL, 1, 31, 10'h3ff));
		push_pair(make_word(EXC_NORMAL, 1, 0, 0), make_word(EXC_NORMAL, 1, 0, 0));
		end_test("range", start);
	endtask

	task automatic test_streaming();
		int start;
		int gaps;
		start = err_cnt;
		gaps = gap_cnt;
		for (int i = 0; i < 5 * `FPM_LANES; i++)
			push_pair(rand_normal(), rand_normal());
		drain_outputs();
		if (gap_cnt != gaps)
		begin
			$display("Output stream had holes under continuous input");
			err_cnt++;
		end
		report_test("streaming", start);
	endtask

	task automatic test_reset();
		int start;
		start = err_cnt;
		// Reset drops half a group
		drive_pair(rand_normal(), rand_normal());
		drive_pair(rand_normal(), rand_normal());
		@(negedge clk);
		in_valid_i = 1'b0;
		rst_i = 1'b1;
		idle_cycles(3);
		rst_i = 1'b0;
		idle_cycles(10);
		for (int i = 0; i < `FPM_LANES; i++)
			push_pair(rand_normal(), rand_normal());
		idle_cycles(1);
		// Random traffic with idle gaps of 0 to 3 cycles
		for (int i = 0; i < 200; i++)
		begin
			push_pair(rand_normal(), rand_normal());
			idle_cycles(rand_bits(2));
		end
		end_test("reset_random", start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		rst_i = 1'b1;
		in_valid_i = 1'b0;
		a_i = '0;
		b_i = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_i = 1'b0;
		test_exc_table();
		test_exact();
		test_rounding();
		test_range();
		test_streaming();
		test_reset();
		$display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial
	begin
		#(LIMIT_CYCLES * 10);
		$display("Simulation hung, results did not arrive within %0d cycles", LIMIT_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
fpm_pkg.sv
special_cases_mul.sv
fpm_operand_dispatch.sv
fpm_lane.sv
fpm_result_collect.sv
fpm_vector_mul.sv
fpm_properties.sv
tb_fpm_vector_mul.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fpm_vector_mul
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
